// File: Makefile
# Verilator build for the render configuration path.

SIM = obj_dir/render_cfg_sim

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module render_cfg_top

sim:
	verilator --binary --timing -f verilog.f --top-module render_cfg_tb -o render_cfg_sim
	./$(SIM) | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/raycast_defines.svh
`ifndef RAYCAST_DEFINES_SVH
`define RAYCAST_DEFINES_SVH

// Every frame opens with a command of this many bits, sent MSB first.
`define RC_CMD_BITS 4

// The payload shift register is as wide as the longest payload (other-cell X and Y).
`define RC_BUF_BITS 12

// Payload lengths per command.
// They are sized to the 7-bit frame bit counter so the end-of-frame compare is exact.
`define RC_LEN_SKY     7'd6   // Sky colour, RRGGBB.
`define RC_LEN_FLOOR   7'd6   // Floor colour, RRGGBB.
`define RC_LEN_LEAK    7'd6   // Floor leak in texels.
`define RC_LEN_OTHER   7'd12  // Other-cell X in the upper half, Y in the lower half.
`define RC_LEN_VSHIFT  7'd6   // Texture V shift.
`define RC_LEN_VINF    7'd1   // Infinite-V flag.

// Codes 6 to 15 still clock in one payload bit before the frame closes.
`define RC_LEN_UNKNOWN 7'd1

// Colours loaded at reset, two bits each of R, G and B.
`define RC_SKY_RESET   6'b010101
`define RC_FLOOR_RESET 6'b101010

`endif // RAYCAST_DEFINES_SVH

// File: common/render_cfg_pkg.sv
// Types that describe the live render configuration seen by the raycaster.
package render_cfg_pkg;

  // A colour with two bits each of R, G and B, laid out as RRGGBB.
  typedef logic [5:0] rgb_t;

  // A 6-bit quantity in texels, or a shift amount.
  typedef logic [5:0] six_t;

  // A map cell position.
  // The layout matches the other-cell payload, x in bits 11:6 and y in bits 5:0.
  typedef struct packed {
    six_t x;  // Map column.
    six_t y;  // Map row.
  } cell_pos_t;

  // Everything the host can set over SPI.
  // Fields only change at vertical blank, so the renderer sees one
  // consistent set for a whole frame.
  typedef struct packed {
    rgb_t      sky;     // Colour drawn above the walls.
    rgb_t      floor;   // Colour drawn below the walls.
    six_t      leak;    // How far the floor leaks up into the wall texture.
    cell_pos_t other;   // The one map cell that uses the alternate wall.
    six_t      vshift;  // Added to texture V.
    logic      vinf;    // Walls repeat V without limit when set.
  } render_cfg_t;

endpackage

// File: common/spi_cmd_pkg.sv
`include "raycast_defines.svh"

// Types that describe the SPI frame as it arrives from the host.
package spi_cmd_pkg;

  // Raw command field, as shifted in from the wire.
  typedef logic [`RC_CMD_BITS-1:0] cmd_t;

  // Commands the renderer understands.
  // Any other code is accepted on the wire but has no effect.
  typedef enum cmd_t {
    CMD_SKY    = 4'd0,  // Sky colour.
    CMD_FLOOR  = 4'd1,  // Floor colour.
    CMD_LEAK   = 4'd2,  // Floor leak.
    CMD_OTHER  = 4'd3,  // Other-cell position.
    CMD_VSHIFT = 4'd4,  // Texture V shift.
    CMD_VINF   = 4'd5   // Infinite-V flag.
  } cmd_e;

  // One received frame.
  // The payload is right-aligned, so a short payload sits in the low bits
  // and whatever lies above it is left over from earlier frames.
  typedef struct packed {
    cmd_t                    cmd;      // Command code.
    logic [`RC_BUF_BITS-1:0] payload;  // Last payload bits shifted in, LSB is the final bit.
  } spi_frame_t;

endpackage

// File: hw/cfg_stage_bank.sv
`timescale 1ns/100ps
`include "raycast_defines.svh"

// Holds received values as pending and makes them live on load_new.
// Each field has its own pending flag, so only the fields the host actually
// wrote since the last vertical blank get replaced.
module cfg_stage_bank (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         frame_done,  // A complete frame is on frame.
  input  logic                         load_new,    // Vertical blank, commit pending values.
  input  spi_cmd_pkg::spi_frame_t      frame,       // Command and right-aligned payload.
  output render_cfg_pkg::render_cfg_t  cfg          // Live configuration for the renderer.
);

  render_cfg_pkg::render_cfg_t pend;  // Pending values, same layout as cfg.

  // Pending flags, one per field.
  logic pend_sky;
  logic pend_floor;
  logic pend_leak;
  logic pend_other;
  logic pend_vshift;
  logic pend_vinf;

  // Write strobes decoded from the finished frame.
  // Codes 6 to 15 match none of them and so leave everything alone.
  logic wr_sky;
  logic wr_floor;
  logic wr_leak;
  logic wr_other;
  logic wr_vshift;
  logic wr_vinf;

  assign wr_sky    = frame_done && (frame.cmd == spi_cmd_pkg::CMD_SKY);
  assign wr_floor  = frame_done && (frame.cmd == spi_cmd_pkg::CMD_FLOOR);
  assign wr_leak   = frame_done && (frame.cmd == spi_cmd_pkg::CMD_LEAK);
  assign wr_other  = frame_done && (frame.cmd == spi_cmd_pkg::CMD_OTHER);
  assign wr_vshift = frame_done && (frame.cmd == spi_cmd_pkg::CMD_VSHIFT);
  assign wr_vinf   = frame_done && (frame.cmd == spi_cmd_pkg::CMD_VINF);

  // Pending values take the low bits of the payload.
  // A repeat write before load_new simply overwrites the older value.
  always_ff @(posedge clk) begin
    if (wr_sky)    pend.sky    <= frame.payload[5:0];
    if (wr_floor)  pend.floor  <= frame.payload[5:0];
    if (wr_leak)   pend.leak   <= frame.payload[5:0];
    if (wr_other)  pend.other  <= frame.payload;       // X in 11:6, Y in 5:0.
    if (wr_vshift) pend.vshift <= frame.payload[5:0];
    if (wr_vinf)   pend.vinf   <= frame.payload[0];
  end

  // Flags and live values.
  // The clear on load_new comes first and a same-cycle write sets the flag
  // again, so a value arriving right at the commit waits for the next blank.
  // The commit itself reads pend before this edge, which is the older value.
  always_ff @(posedge clk) begin
    if (!reset) begin
      cfg.sky     <= `RC_SKY_RESET;
      cfg.floor   <= `RC_FLOOR_RESET;
      cfg.leak    <= 6'd0;
      cfg.other   <= 12'd0;
      cfg.vshift  <= 6'd0;
      cfg.vinf    <= 1'b0;
      pend_sky    <= 1'b0;
      pend_floor  <= 1'b0;
      pend_leak   <= 1'b0;
      pend_other  <= 1'b0;
      pend_vshift <= 1'b0;
      pend_vinf   <= 1'b0;
    end else begin
      if (load_new) begin
        if (pend_sky) begin
          cfg.sky  <= pend.sky;
          pend_sky <= 1'b0;
        end
        if (pend_floor) begin
          cfg.floor  <= pend.floor;
          pend_floor <= 1'b0;
        end
        if (pend_leak) begin
          cfg.leak  <= pend.leak;
          pend_leak <= 1'b0;
        end
        if (pend_other) begin
          cfg.other  <= pend.other;
          pend_other <= 1'b0;
        end
        if (pend_vshift) begin
          cfg.vshift  <= pend.vshift;
          pend_vshift <= 1'b0;
        end
        if (pend_vinf) begin
          cfg.vinf  <= pend.vinf;
          pend_vinf <= 1'b0;
        end
      end
      if (wr_sky)    pend_sky    <= 1'b1;
      if (wr_floor)  pend_floor  <= 1'b1;
      if (wr_leak)   pend_leak   <= 1'b1;
      if (wr_other)  pend_other  <= 1'b1;
      if (wr_vshift) pend_vshift <= 1'b1;
      if (wr_vinf)   pend_vinf   <= 1'b1;
    end
  end

endmodule

// File: hw/render_cfg_top.sv
`timescale 1ns/100ps

// Host configuration path of the raycasting renderer.
// SPI pins come in raw, the render configuration goes out, and new values
// only show up on cfg one cycle after the renderer pulses load_new.
module render_cfg_top (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        sclk,      // SPI clock, host driven.
  input  logic                        ss_n,      // SPI select, active low.
  input  logic                        mosi,      // SPI data in.
  input  logic                        load_new,  // Pulsed by the renderer at vertical blank.
  output render_cfg_pkg::render_cfg_t cfg        // Live configuration.
);

  logic                    sclk_rise;   // SCLK rising edge in clk domain.
  logic                    ss_active;   // Select asserted, synchronized.
  logic                    mosi_s;      // Data, synchronized.
  logic                    frame_done;  // A frame has just completed.
  spi_cmd_pkg::spi_frame_t frame;       // The completed frame.

  // Three clk stages on SCLK before an edge is seen.
  spi_line_sync sync_i (
    .clk       (clk),
    .reset     (reset),
    .sclk      (sclk),
    .ss_n      (ss_n),
    .mosi      (mosi),
    .sclk_rise (sclk_rise),
    .ss_active (ss_active),
    .mosi_s    (mosi_s)
  );

  spi_frame_ctrl ctrl_i (
    .clk        (clk),
    .reset      (reset),
    .sclk_rise  (sclk_rise),
    .ss_active  (ss_active),
    .mosi_s     (mosi_s),
    .frame_done (frame_done),
    .frame      (frame)
  );

  // The value is pending one cycle after frame_done.
  cfg_stage_bank bank_i (
    .clk        (clk),
    .reset      (reset),
    .frame_done (frame_done),
    .load_new   (load_new),
    .frame      (frame),
    .cfg        (cfg)
  );

endmodule

// File: hw/spi_line_sync.sv
`timescale 1ns/100ps

// Brings the three SPI lines into the clk domain.
// SCLK gets a third stage so its rising edge can be found from stages 2 and 3.
module spi_line_sync (
  input  logic clk,
  input  logic reset,
  input  logic sclk,       // Raw SPI clock from the host.
  input  logic ss_n,       // Raw select, low while a transfer is open.
  input  logic mosi,       // Raw data from the host.
  output logic sclk_rise,  // One-cycle pulse per SCLK rising edge.
  output logic ss_active,  // High while select is asserted.
  output logic mosi_s      // Data line, safe to sample on sclk_rise.
);

  logic [2:0] sclk_sh;  // Bit 0 is the newest sample.
  logic [1:0] ss_sh;
  logic [1:0] mosi_sh;

  always_ff @(posedge clk) begin
    if (!reset) begin
      sclk_sh <= 3'b000;
      ss_sh   <= 2'b11;   // Select reads as inactive out of reset.
      mosi_sh <= 2'b00;
    end else begin
      sclk_sh <= {sclk_sh[1:0], sclk};
      ss_sh   <= {ss_sh[0], ss_n};
      mosi_sh <= {mosi_sh[0], mosi};
    end
  end

  // Stage 3 still low while stage 2 is already high marks a fresh rising edge.
  assign sclk_rise = (sclk_sh[2:1] == 2'b01);

  // Select only matters as a level, two stages are enough.
  assign ss_active = ~ss_sh[1];

  // The host holds MOSI for several clk cycles around the edge.
  // By the time sclk_rise fires this stage has long settled.
  assign mosi_s = mosi_sh[1];

endmodule

// File: spi/spi_frame_ctrl.sv
`timescale 1ns/100ps
`include "raycast_defines.svh"

// Frame control for the configuration SPI port.
// Counts bits inside a select period, shifts the command and then the payload,
// and raises frame_done once the last payload bit is in.
module spi_frame_ctrl (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    sclk_rise,   // One pulse per SCLK rising edge.
  input  logic                    ss_active,   // Select level, already synchronized.
  input  logic                    mosi_s,      // Data bit, already synchronized.
  output logic                    frame_done,  // One-cycle pulse after the last bit.
  output spi_cmd_pkg::spi_frame_t frame        // Held until the next frame's bits arrive.
);

  logic [6:0] bit_cnt;   // Position in the current frame, 0 is the command MSB.
  logic [6:0] pay_len;   // Payload length for the command received so far.
  logic [6:0] last_bit;  // Value of bit_cnt at the final payload bit.
  logic       in_cmd;    // Still receiving command bits.
  logic       frame_end; // The bit now arriving closes the frame.
  logic       bit_in;    // A data bit is being clocked in this cycle.

  // Look up the payload length.
  // While the command is still shifting this result is meaningless, but
  // frame_end is only consulted once all command bits are in.
  always_comb begin
    case (frame.cmd)
      spi_cmd_pkg::CMD_SKY:    pay_len = `RC_LEN_SKY;
      spi_cmd_pkg::CMD_FLOOR:  pay_len = `RC_LEN_FLOOR;
      spi_cmd_pkg::CMD_LEAK:   pay_len = `RC_LEN_LEAK;
      spi_cmd_pkg::CMD_OTHER:  pay_len = `RC_LEN_OTHER;
      spi_cmd_pkg::CMD_VSHIFT: pay_len = `RC_LEN_VSHIFT;
      spi_cmd_pkg::CMD_VINF:   pay_len = `RC_LEN_VINF;
      default:                 pay_len = `RC_LEN_UNKNOWN;  // Codes 6 to 15.
    endcase
  end

  assign last_bit  = 7'(`RC_CMD_BITS) + pay_len - 7'd1;
  assign in_cmd    = (bit_cnt < 7'(`RC_CMD_BITS));
  assign frame_end = !in_cmd && (bit_cnt == last_bit);
  assign bit_in    = ss_active && sclk_rise;

  // Bit counter.
  // Dropping select clears it at any point, which throws away a partial frame.
  // Wrapping to zero at the end lets the host send back-to-back frames.
  always_ff @(posedge clk) begin
    if (!reset || !ss_active) begin
      bit_cnt <= 7'd0;
    end else if (sclk_rise) begin
      bit_cnt <= frame_end ? 7'd0 : bit_cnt + 7'd1;
    end
  end

  // Command and payload shift registers, MSB first.
  // The payload only shifts once the command is complete, so a short payload
  // ends up right-aligned in the low bits.
  always_ff @(posedge clk) begin
    if (bit_in) begin
      if (in_cmd) begin
        frame.cmd <= {frame.cmd[`RC_CMD_BITS-2:0], mosi_s};
      end else begin
        frame.payload <= {frame.payload[`RC_BUF_BITS-2:0], mosi_s};
      end
    end
  end

  // Completion pulse, one cycle after the last bit was taken.
  // The next SCLK edge is several cycles away, so frame is stable while this is high.
  always_ff @(posedge clk) begin
    if (!reset) begin
      frame_done <= 1'b0;
    end else begin
      frame_done <= bit_in && frame_end;
    end
  end

endmodule

// File: tb/render_cfg_tb.sv
`timescale 1ns/100ps

// Testbench for the host configuration path.
// Bit-bangs SPI frames into the DUT and checks cfg against a staging model.
module render_cfg_tb;

  logic clk;
  logic reset;
  logic sclk;
  logic ss_n;
  logic mosi;
  logic load_new;
  render_cfg_pkg::render_cfg_t cfg;

  logic [31:0] rng_state;  // LCG state.
  int errors;
  int checks;
  int tests_run;
  int tests_failed;
  int test_err_base;       // Error count when the current test started.

  // The model keeps a copy of each field, indexed by command code 0 to 5.
  logic [11:0] model_pend [6];
  logic        model_flag [6];
  logic [11:0] model_live [6];

  render_cfg_top dut_i (
    .clk      (clk),
    .reset    (reset),
    .sclk     (sclk),
    .ss_n     (ss_n),
    .mosi     (mosi),
    .load_new (load_new),
    .cfg      (cfg)
  );

  always #20 clk = ~clk;  // 40 ns clock.

  // The upper half of the LCG state has the better randomness.
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {16'd0, rng_state[31:16]};
  endfunction

  function automatic int payload_len(input logic [3:0] cmd);
    case (cmd)
      4'd0, 4'd1, 4'd2, 4'd4: payload_len = 6;
      4'd3:                   payload_len = 12;  // X and Y together.
      default:                payload_len = 1;   // Infinite-V flag and the unknown codes.
    endcase
  endfunction

  function automatic logic [11:0] len_mask(input logic [3:0] cmd);
    return 12'hfff >> (12 - payload_len(cmd));
  endfunction

  // Live configuration as the model expects it.
  function automatic render_cfg_pkg::render_cfg_t expected_cfg();
    render_cfg_pkg::render_cfg_t exp;
    exp.sky     = model_live[0][5:0];
    exp.floor   = model_live[1][5:0];
    exp.leak    = model_live[2][5:0];
    exp.other.x = model_live[3][11:6];  // Upper payload half is the column.
    exp.other.y = model_live[3][5:0];
    exp.vshift  = model_live[4][5:0];
    exp.vinf    = model_live[5][0];
    return exp;
  endfunction

  // A completed frame becomes pending, and a repeat write overwrites it.
  task automatic model_stage(input logic [3:0] cmd, input logic [11:0] payload);
    if (cmd < 4'd6) begin
      model_pend[cmd[2:0]] = payload & len_mask(cmd);
      model_flag[cmd[2:0]] = 1'b1;
    end
  endtask

  task automatic model_commit();
    for (int i = 0; i < 6; i++) begin
      if (model_flag[i]) begin
        model_live[i] = model_pend[i];
        model_flag[i] = 1'b0;
      end
    end
  endtask

  task automatic check_value(input string what, input render_cfg_pkg::render_cfg_t got,
                             input render_cfg_pkg::render_cfg_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic hold(input int n);
    repeat (n) @(posedge clk);
  endtask

  // Sends one SPI bit with each SCLK level held for 4 clk cycles.
  task automatic send_bit(input logic b);
    @(posedge clk);
    sclk <= 1'b0;
    mosi <= b;  // Data changes while SCLK is low.
    hold(3);
    @(posedge clk);
    sclk <= 1'b1;
    hold(3);
  endtask

  task automatic open_select();
    @(posedge clk);
    ss_n <= 1'b0;
    sclk <= 1'b0;
    hold(3);
  endtask

  task automatic close_select();
    @(posedge clk);
    sclk <= 1'b0;
    hold(3);
    @(posedge clk);
    ss_n <= 1'b1;
    hold(3);  // Select stays high long enough to be seen.
  endtask

  // Shifts command then payload MSB first, stopping after stop_at bits.
  task automatic shift_frame(input logic [3:0] cmd, input logic [11:0] payload,
                             input int stop_at);
    logic [15:0] word;
    int total;
    total = 4 + payload_len(cmd);
    word = (16'(cmd) << payload_len(cmd)) | 16'(payload & len_mask(cmd));
    for (int i = 0; i < total && i < stop_at; i++) begin
      send_bit(word[total - 1 - i]);
    end
  endtask

  task automatic send_frame(input logic [3:0] cmd, input logic [11:0] payload);
    open_select();
    shift_frame(cmd, payload, 16);
    close_select();
    model_stage(cmd, payload);
    hold(8);  // Settle time before any load_new.
  endtask

  // Raises select after stop_at bits, so the frame never completes.
  task automatic send_aborted(input logic [3:0] cmd, input logic [11:0] payload,
                              input int stop_at);
    open_select();
    shift_frame(cmd, payload, stop_at);
    close_select();
    hold(8);
  endtask

  task automatic check_idle(input string what);
    @(negedge clk);  // cfg only moves on the rising edge.
    check_value(what, cfg, expected_cfg());
  endtask

  task automatic commit_and_check(input string what);
    int waited;
    @(posedge clk);
    load_new <= 1'b1;
    @(posedge clk);
    load_new <= 1'b0;
    model_commit();
    waited = 0;
    @(negedge clk);
    while (cfg !== expected_cfg() && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (cfg !== expected_cfg())
      $display("Timeout: cfg did not settle within 4 cycles after load_new");
    check_value(what, cfg, expected_cfg());
  endtask

  function automatic logic [3:0] rand_cmd();
    return 4'(next_rand() % 32'd6);
  endfunction

  task automatic end_test(input string name);
    tests_run++;
    if (errors != test_err_base) begin
      tests_failed++;
      $display("Test %0d, %s: FAILED", tests_run, name);
    end else begin
      $display("Test %0d, %s: passed", tests_run, name);
    end
    test_err_base = errors;
  endtask

  task automatic test_single_fields();
    logic [3:0] cmd;
    for (int i = 0; i < 12; i++) begin
      cmd = (i < 6) ? 4'(i) : rand_cmd();  // Every command at least once.
      send_frame(cmd, 12'(next_rand()));
      check_idle("cfg changed before load_new");
      commit_and_check("field after load_new");
    end
  endtask

  task automatic test_double_write();
    logic [3:0] cmd;
    for (int i = 0; i < 4; i++) begin
      cmd = rand_cmd();
      send_frame(cmd, 12'(next_rand()));
      send_frame(cmd, 12'(next_rand()));  // Only this one should go live.
      commit_and_check("second write wins");
    end
  endtask

  task automatic test_discarded();
    logic [3:0] cmd;
    cmd = 4'(next_rand() % 32'd5);       // Codes 0 to 4 all have 6 or more payload bits.
    send_aborted(cmd, 12'(next_rand()), 7);  // Select rises mid-payload.
    send_frame(4'(32'd6 + next_rand() % 32'd10), 12'(next_rand()));
    check_idle("cfg changed by a discarded frame");
    commit_and_check("nothing staged by discarded frames");
    send_frame(rand_cmd(), 12'(next_rand()));
    commit_and_check("valid frame after discard");
  endtask

  // Back-to-back frames inside one select period.
  task automatic multi_frame(input int count);
    logic [3:0] cmd;
    logic [11:0] payload;
    open_select();
    for (int k = 0; k < count; k++) begin
      cmd = (count == 6) ? 4'(k) : rand_cmd();
      payload = 12'(next_rand());
      shift_frame(cmd, payload, 16);
      model_stage(cmd, payload);
    end
    close_select();
    hold(8);
  endtask

  task automatic test_multi_frame();
    multi_frame(6);
    check_idle("cfg changed before load_new");
    commit_and_check("all frames commit together");
  endtask

  task automatic test_random_run();
    logic [3:0] cmd;
    int action;
    int stop_at;
    for (int i = 0; i < 60; i++) begin
      action = int'(next_rand() % 32'd8);
      case (action)
        5: begin
          cmd = 4'(next_rand());
          stop_at = 1 + int'(next_rand() % 32'(3 + payload_len(cmd)));
          send_aborted(cmd, 12'(next_rand()), stop_at);
        end
        6: send_frame(4'(32'd6 + next_rand() % 32'd10), 12'(next_rand()));
        7: multi_frame(2 + int'(next_rand() % 32'd3));
        default: send_frame(rand_cmd(), 12'(next_rand()));
      endcase
      if (next_rand() % 32'd3 == 32'd0)
        commit_and_check("random run commit");
      else
        check_idle("random run idle");
    end
    commit_and_check("random run final commit");
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b0;
    sclk = 1'b0;
    ss_n = 1'b1;
    mosi = 1'b0;
    load_new = 1'b0;
    rng_state = 32'h6ced4714;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    test_err_base = 0;
    for (int i = 0; i < 6; i++) begin
      model_pend[i] = 12'd0;
      model_flag[i] = 1'b0;
      model_live[i] = 12'd0;
    end
    model_live[0] = 12'b000000_010101;  // Sky reset colour.
    model_live[1] = 12'b000000_101010;  // Floor reset colour.

    repeat (4) @(posedge clk);
    reset <= 1'b1;
    hold(2);

    check_idle("defaults after reset");
    end_test("reset defaults");
    test_single_fields();
    end_test("single field staging");
    test_double_write();
    end_test("double write");
    test_discarded();
    end_test("aborted and unknown frames");
    test_multi_frame();
    end_test("frames in one select");
    test_random_run();
    end_test("random run");

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+common
common/spi_cmd_pkg.sv
common/render_cfg_pkg.sv
hw/spi_line_sync.sv
spi/spi_frame_ctrl.sv
hw/cfg_stage_bank.sv
hw/render_cfg_top.sv
tb/render_cfg_tb.sv
